//--- hdl/axi_rd_split_pkg.sv
/* shared widths, sizes and types of the read burst splitter.
   incr bursts only, fixed 64-bit beats, no 4 KB boundary handling.
   flag_depth must stay a power of two, since the FIFO pointers wrap freely. */
package axi_rd_split_pkg;

    // beat and piece geometry.
    localparam int beat_bytes   = 8;                        // 64-bit data beat.
    localparam int part_beats   = 16;                       // max beats per short burst.
    localparam int piece_stride = part_beats * beat_bytes;  // byte step between pieces.

    // outstanding short bursts.
    localparam int flag_depth   = 8;                        // FIFO entries.
    localparam int flag_ptr_w   = $clog2(flag_depth);       // pointer bits.

    // AXI field widths.
    typedef logic [3:0]  id_t;                              // transaction id.
    typedef logic [31:0] addr_t;                            // byte address.
    typedef logic [7:0]  len_t;                             // beats minus one.
    typedef logic [63:0] data_t;                            // one read beat.

    // beats still to issue, 1 to 256.
    typedef logic [8:0]  beats_t;

    // FIFO bookkeeping.
    typedef logic [flag_ptr_w-1:0] flag_ptr_t;              // read/write pointer.
    typedef logic [flag_ptr_w:0]   flag_cnt_t;              // occupancy, 0 to depth.

    // read address channel payload, 44 bits.
    typedef struct packed {
        id_t   id;                                          // kept on every piece.
        addr_t addr;                                        // start address.
        len_t  len;                                         // beats minus one.
    } rd_req_t;

    // read data channel payload, 71 bits.
    typedef struct packed {
        id_t        id;                                     // passed through.
        data_t      data;                                   // beat data.
        logic [1:0] resp;                                   // okay/slverr etc.
        logic       last;                                   // end of burst.
    } rd_beat_t;

    // partitioner FSM.
    typedef enum logic {
        idle,                                               // waiting for a long request.
        issue                                               // sending pieces.
    } part_state_t;

    // note: the merger relies on responses coming back in request order,
    // which holds as long as only one id stream is used.

endpackage

//--- hdl/burst_partitioner.sv
/* cuts one long incr read burst into pieces of at most part_beats beats.
   one long request is handled at a time; long_arready is low while issuing.
   issue also stalls while the flag FIFO is full. */
module burst_partitioner (
    input  logic                      clock,
    input  logic                      rst_n,
    input  axi_rd_split_pkg::rd_req_t long_ar,
    input  logic                      long_arvalid,
    output logic                      long_arready,
    output axi_rd_split_pkg::rd_req_t short_ar,
    output logic                      short_arvalid,
    input  logic                      short_arready,
    input  logic                      flag_full,
    output logic                      flag_push,
    output logic                      flag_final
);
    import axi_rd_split_pkg::*;

    part_state_t state;                 // FSM state.
    id_t         req_id;                // id of the long request.
    addr_t       next_addr;             // start of the next piece.
    beats_t      rem_beats;             // beats not yet issued.
    logic        long_fire;             // long AR transfer.
    logic        short_fire;            // short AR transfer.
    logic        last_piece;            // current piece ends the burst.

    // handshake.
    assign long_arready  = (state == idle);            // accept only when idle.
    assign long_fire     = long_arvalid & long_arready;
    assign last_piece    = (rem_beats <= beats_t'(part_beats));
    // flag_full only rises on a push, so valid never drops before its transfer.
    assign short_arvalid = (state == issue) & ~flag_full;
    assign short_fire    = short_arvalid & short_arready;

    // piece request.
    always_comb begin
        short_ar.id   = req_id;                         // same id on every piece.
        short_ar.addr = next_addr;
        if (last_piece) begin
            short_ar.len = len_t'(rem_beats - beats_t'(1));  // remainder.
        end else begin
            short_ar.len = len_t'(part_beats - 1);           // full piece.
        end
    end

    // one flag per issued piece, set on the final one.
    assign flag_push  = short_fire;
    assign flag_final = last_piece;

    // control.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            rem_beats <= '0;
        end else begin
            case (state)
                idle: begin
                    if (long_fire) begin
                        state     <= issue;                          // valid next cycle.
                        rem_beats <= beats_t'(long_ar.len) + beats_t'(1);
                    end
                end
                issue: begin
                    if (short_fire) begin
                        if (last_piece) begin
                            state <= idle;                           // ready next cycle.
                        end else begin
                            rem_beats <= rem_beats - beats_t'(part_beats);
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // request payload.
    always_ff @(posedge clock) begin
        if (long_fire) begin
            req_id    <= long_ar.id;
            next_addr <= long_ar.addr;                               // first piece start.
        end else if (short_fire && !last_piece) begin
            next_addr <= next_addr + addr_t'(piece_stride);          // next piece start.
        end
    end

    // a piece never exceeds the short burst limit.
    a_short_len: assert property (
        @(posedge clock) disable iff (!rst_n)
        short_arvalid |-> (short_ar.len <= len_t'(part_beats - 1))
    ) else $error("short_ar.len %0h above piece limit", short_ar.len);

    // a stalled piece keeps its payload until the slave takes it.
    a_short_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (short_arvalid && !short_arready) |=> (short_arvalid && $stable(short_ar))
    ) else $error("short AR dropped or changed before transfer");

    // the final flag goes with the piece that ends the long request.
    a_push_final: assert property (
        @(posedge clock) disable iff (!rst_n)
        flag_push |=> (long_arready == $past(flag_final))
    ) else $error("final piece flag does not match the end of the request");

endmodule

//--- hdl/piece_flag_fifo.sv
/* small FIFO of final-piece flags, one entry per short burst in flight.
   a push shows at the head one cycle later; the head is read without latency.
   no bypass, and the user must not push when full or pop when empty. */
module piece_flag_fifo (
    input  logic clock,
    input  logic rst_n,
    input  logic flag_push,
    input  logic flag_final,
    input  logic flag_pop,
    output logic head_final,
    output logic flag_full,
    output logic flag_empty
);
    import axi_rd_split_pkg::*;

    logic [flag_depth-1:0] flags;       // flag storage.
    flag_ptr_t             wr_ptr;      // next free slot.
    flag_ptr_t             rd_ptr;      // oldest entry.
    flag_cnt_t             count;       // entries held.

    // status.
    assign flag_full  = (count == flag_cnt_t'(flag_depth));
    assign flag_empty = (count == '0);
    assign head_final = flags[rd_ptr];                  // oldest flag.

    // storage.
    always_ff @(posedge clock) begin
        if (flag_push) begin
            flags[wr_ptr] <= flag_final;
        end
    end

    // pointers and occupancy.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (flag_push) begin
                wr_ptr <= wr_ptr + flag_ptr_t'(1);      // wraps at depth.
            end
            if (flag_pop) begin
                rd_ptr <= rd_ptr + flag_ptr_t'(1);
            end
            case ({flag_push, flag_pop})
                2'b10:   count <= count + flag_cnt_t'(1);
                2'b01:   count <= count - flag_cnt_t'(1);
                default: count <= count;                // both or none.
            endcase
        end
    end

    // the partitioner must respect flag_full.
    a_no_overflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(flag_push && flag_full)
    ) else $error("flag push while FIFO full");

    // every returning short burst must have a flag.
    a_no_underflow: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(flag_pop && flag_empty)
    ) else $error("flag pop while FIFO empty");

endmodule

//--- hdl/read_return_merger.sv
/* passes short read beats to the long side with no latency.
   rlast of the long burst comes from the head flag of the piece FIFO,
   so short bursts must return in issue order. */
module read_return_merger (
    input  logic                       clock,
    input  logic                       rst_n,
    input  axi_rd_split_pkg::rd_beat_t short_r,
    input  logic                       short_rvalid,
    output logic                       short_rready,
    output axi_rd_split_pkg::rd_beat_t long_r,
    output logic                       long_rvalid,
    input  logic                       long_rready,
    input  logic                       head_final,
    input  logic                       flag_empty,
    output logic                       flag_pop
);
    import axi_rd_split_pkg::*;

    logic short_fire;                   // short R transfer.

    // beat path.
    always_comb begin
        long_r      = short_r;                          // id, data, resp as is.
        long_r.last = short_r.last & head_final;        // only the final piece ends it.
    end

    // handshake straight through.
    assign long_rvalid  = short_rvalid;
    assign short_rready = long_rready;                  // stall with no loss.
    assign short_fire   = short_rvalid & short_rready;

    // one pop per completed short burst.
    assign flag_pop = short_fire & short_r.last;

    // a short burst cannot end before its piece was issued.
    a_flag_present: assert property (
        @(posedge clock) disable iff (!rst_n)
        (short_rvalid && short_r.last) |-> !flag_empty
    ) else $error("short rlast with no piece outstanding");

    // a stalled beat keeps its payload on the long side.
    a_long_hold: assert property (
        @(posedge clock) disable iff (!rst_n)
        (long_rvalid && !long_rready) |=> (long_rvalid && $stable(long_r))
    ) else $error("long R beat changed before transfer");

endmodule

//--- hdl/axi_rd_split.sv
/* read address burst splitter, long AXI read port to short AXI read port.
   incr bursts only, single id stream, responses in request order.
   up to flag_depth short bursts may be outstanding at once. */
module axi_rd_split (
    input  logic                       clock,
    input  logic                       rst_n,
    // long side, from the master.
    input  axi_rd_split_pkg::rd_req_t  long_ar,
    input  logic                       long_arvalid,
    output logic                       long_arready,
    output axi_rd_split_pkg::rd_beat_t long_r,
    output logic                       long_rvalid,
    input  logic                       long_rready,
    // short side, to the slave.
    output axi_rd_split_pkg::rd_req_t  short_ar,
    output logic                       short_arvalid,
    input  logic                       short_arready,
    input  axi_rd_split_pkg::rd_beat_t short_r,
    input  logic                       short_rvalid,
    output logic                       short_rready
);

    logic flag_push;                    // piece issued.
    logic flag_final;                   // issued piece ends its burst.
    logic flag_pop;                     // short burst returned.
    logic head_final;                   // oldest piece flag.
    logic flag_full;                    // issue must stall.
    logic flag_empty;                   // nothing outstanding.

    burst_partitioner i_partitioner (
        .clock         (clock),
        .rst_n         (rst_n),
        .long_ar       (long_ar),
        .long_arvalid  (long_arvalid),
        .long_arready  (long_arready),
        .short_ar      (short_ar),
        .short_arvalid (short_arvalid),
        .short_arready (short_arready),
        .flag_full     (flag_full),
        .flag_push     (flag_push),
        .flag_final    (flag_final)
    );

    piece_flag_fifo i_flag_fifo (
        .clock      (clock),
        .rst_n      (rst_n),
        .flag_push  (flag_push),
        .flag_final (flag_final),
        .flag_pop   (flag_pop),
        .head_final (head_final),
        .flag_full  (flag_full),
        .flag_empty (flag_empty)
    );

    read_return_merger i_merger (
        .clock        (clock),
        .rst_n        (rst_n),
        .short_r      (short_r),
        .short_rvalid (short_rvalid),
        .short_rready (short_rready),
        .long_r       (long_r),
        .long_rvalid  (long_rvalid),
        .long_rready  (long_rready),
        .head_final   (head_final),
        .flag_empty   (flag_empty),
        .flag_pop     (flag_pop)
    );

endmodule

//--- testbench/tb_axi_rd_split.sv
/* testbench for the read burst splitter, stimulus and stall rates from the trace file.
   the slave model answers in request order with data equal to the beat byte address.
   run from the project root so that the trace path resolves. */
module tb_axi_rd_split;
    timeunit 1ns;
    timeprecision 1ps;
    import axi_rd_split_pkg::*;

    localparam int clock_period = 100;
    localparam int reset_cycles = 5;
    localparam int max_cycles   = 20000;    // ~2200 trace beats at up to 70% stall, with margin.

    logic     clock;
    logic     rst_n;
    rd_req_t  long_ar;
    logic     long_arvalid;
    logic     long_arready;
    rd_beat_t long_r;
    logic     long_rvalid;
    logic     long_rready;
    rd_req_t  short_ar;
    logic     short_arvalid;
    logic     short_arready;
    rd_beat_t short_r;
    logic     short_rvalid;
    logic     short_rready;

    rd_req_t  trace_req[$];                 // long requests from the trace.
    int       trace_pieces[$];              // expected short AR count.
    int       trace_ar_stall[$];            // short_arready stall percent.
    int       trace_r_stall[$];             // long_rready stall percent.
    int       pieces_seen[$];               // short ARs seen per long request.
    int       cur_req;                      // last long request taken by the DUT.
    rd_req_t  exp_ar[$];                    // pieces still to come.
    rd_beat_t exp_r[$];                     // long beats still to come.
    rd_req_t  slave_q[$];                   // accepted short requests.
    int       slave_beat;                   // beat index in slave_q[0].
    int       ar_stall_pct;
    int       r_stall_pct;
    integer   seed;
    int       cycles;
    int       beats_seen;
    int       ar_errs;                      // wrong short AR fields.
    int       r_errs;                       // wrong long R beats.
    int       ctl_errs;                     // reset state, counts, timeout.

    axi_rd_split i_dut (
        .clock         (clock),
        .rst_n         (rst_n),
        .long_ar       (long_ar),
        .long_arvalid  (long_arvalid),
        .long_arready  (long_arready),
        .long_r        (long_r),
        .long_rvalid   (long_rvalid),
        .long_rready   (long_rready),
        .short_ar      (short_ar),
        .short_arvalid (short_arvalid),
        .short_arready (short_arready),
        .short_r       (short_r),
        .short_rvalid  (short_rvalid),
        .short_rready  (short_rready)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // columns: id addr len pieces ar_stall r_stall.
    task automatic load_trace(output bit ok);
        int          fd;
        string       line;
        logic [31:0] id;
        logic [31:0] addr;
        logic [31:0] len;
        int          pcs;
        int          ars;
        int          rs;
        rd_req_t     req;
        ok = 1'b0;
        fd = $fopen("testbench/axi_rd_split_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %h %h %d %d %d", id, addr, len, pcs, ars, rs) == 6) begin
                    req.id   = id_t'(id);
                    req.addr = addr_t'(addr);
                    req.len  = len_t'(len);
                    trace_req.push_back(req);
                    trace_pieces.push_back(pcs);
                    trace_ar_stall.push_back(ars);
                    trace_r_stall.push_back(rs);
                    pieces_seen.push_back(0);
                end
            end
            $fclose(fd);
            ok = (trace_req.size() > 0);
            if (!ok) $display("the trace file holds no requests");
        end
    endtask

    // pieces and beats of one long request, from the piece rule.
    task automatic expect_request(input int idx);
        rd_req_t  req;
        rd_req_t  piece;
        rd_beat_t beat;
        int       n;
        int       pieces;
        req    = trace_req[idx];
        n      = int'(req.len) + 1;
        pieces = (n + part_beats - 1) / part_beats;         // ceiling.
        for (int k = 0; k < pieces; k++) begin
            piece.id   = req.id;
            piece.addr = req.addr + addr_t'(k * part_beats * beat_bytes);
            if (k == pieces - 1) piece.len = len_t'(n - k * part_beats - 1);   // remainder.
            else piece.len = len_t'(part_beats - 1);
            exp_ar.push_back(piece);
        end
        for (int i = 0; i < n; i++) begin
            beat.id   = req.id;
            beat.data = data_t'(req.addr + addr_t'(i * beat_bytes));
            beat.resp = 2'b00;
            beat.last = (i == n - 1);                       // only the final beat.
            exp_r.push_back(beat);
        end
    endtask

    // called on a rising edge, returns on the edge of the AR transfer.
    task automatic drive_request(input int idx);
        expect_request(idx);
        ar_stall_pct <= trace_ar_stall[idx];
        r_stall_pct  <= trace_r_stall[idx];
        long_ar      <= trace_req[idx];
        long_arvalid <= 1'b1;
        do @(posedge clock); while (!long_arready);
    endtask

    task automatic check_short_ar();
        rd_req_t want;
        assert (exp_ar.size() != 0 && cur_req >= 0) else begin
            ctl_errs++;
            $display("short AR transfer while no piece was expected");
        end
        if (exp_ar.size() != 0 && cur_req >= 0) begin
            want = exp_ar.pop_front();
            pieces_seen[cur_req]++;
            assert (short_ar.id == want.id) else begin
                ar_errs++;
                $display("ERROR: short_ar.id got %h expected %h", short_ar.id, want.id);
            end
            assert (short_ar.addr == want.addr) else begin
                ar_errs++;
                $display("ERROR: short_ar.addr got %h expected %h", short_ar.addr, want.addr);
            end
            assert (short_ar.len == want.len) else begin
                ar_errs++;
                $display("ERROR: short_ar.len got %h expected %h", short_ar.len, want.len);
            end
        end
    endtask

    task automatic check_long_beat();
        rd_beat_t want;
        beats_seen++;
        assert (exp_r.size() != 0) else begin
            ctl_errs++;
            $display("long R beat arrived while no beat was expected");
        end
        if (exp_r.size() != 0) begin
            want = exp_r.pop_front();
            assert (long_r.data == want.data) else begin
                r_errs++;
                $display("ERROR: long_r.data got %h expected %h", long_r.data, want.data);
            end
            assert (long_r.id == want.id) else begin
                r_errs++;
                $display("ERROR: long_r.id got %h expected %h", long_r.id, want.id);
            end
            assert (long_r.resp == want.resp) else begin
                r_errs++;
                $display("ERROR: long_r.resp got %h expected %h", long_r.resp, want.resp);
            end
            assert (long_r.last == want.last) else begin
                r_errs++;
                $display("ERROR: long_r.last got %h expected %h", long_r.last, want.last);
            end
        end
    endtask

    task automatic check_reset_state();
        assert (long_arready == 1'b1) else begin
            ctl_errs++;
            $display("ERROR: long_arready got %h expected 1", long_arready);
        end
        assert (short_arvalid == 1'b0) else begin
            ctl_errs++;
            $display("ERROR: short_arvalid got %h expected 0", short_arvalid);
        end
        assert (long_rvalid == 1'b0) else begin
            ctl_errs++;
            $display("ERROR: long_rvalid got %h expected 0", long_rvalid);
        end
    endtask

    task automatic check_piece_counts();
        foreach (trace_pieces[i]) begin
            assert (pieces_seen[i] == trace_pieces[i]) else begin
                ctl_errs++;
                $display("ERROR: short_ar count of request %0d got %h expected %h",
                         i, pieces_seen[i], trace_pieces[i]);
            end
        end
    endtask

    // slave beat for a short request.
    function automatic rd_beat_t make_beat(input rd_req_t req, input int beat);
        rd_beat_t b;
        b.id   = req.id;
        b.data = data_t'(req.addr + addr_t'(beat * beat_bytes));
        b.resp = 2'b00;
        b.last = (beat == int'(req.len));
        return b;
    endfunction

    task automatic close_run();
        $display("errors: short_ar %0d, long_r %0d, control %0d; beats checked %0d",
                 ar_errs, r_errs, ctl_errs, beats_seen);
        if (ar_errs + r_errs + ctl_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // short-side slave and long R monitor.
    always @(posedge clock) begin
        if (!rst_n) begin
            short_arready <= 1'b0;
            short_rvalid  <= 1'b0;
            long_rready   <= 1'b0;
        end else begin
            if (short_arvalid && short_arready) begin
                check_short_ar();
                slave_q.push_back(short_ar);
            end
            if (long_arvalid && long_arready) cur_req++;   // later pieces belong to it.
            if (short_rvalid && short_rready) begin
                if (short_r.last) begin
                    void'(slave_q.pop_front());             // burst done.
                    slave_beat = 0;
                end else begin
                    slave_beat++;
                end
            end
            if (long_rvalid && long_rready) check_long_beat();
            if (slave_q.size() != 0) begin
                short_rvalid <= 1'b1;
                short_r      <= make_beat(slave_q[0], slave_beat);
            end else begin
                short_rvalid <= 1'b0;
            end
            short_arready <= ({$random(seed)} % 100) >= ar_stall_pct;
            long_rready   <= ({$random(seed)} % 100) >= r_stall_pct;
        end
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= max_cycles) begin
            ctl_errs++;
            $display("timeout after %0d cycles with %0d beats and %0d pieces still expected",
                     cycles, exp_r.size(), exp_ar.size());
            close_run();
        end
    end

    initial begin
        bit ok;
        seed          = 91814;
        rst_n         = 1'b0;
        long_ar       = '0;
        long_arvalid  = 1'b0;
        long_rready   = 1'b0;
        short_arready = 1'b0;
        short_r       = '0;
        short_rvalid  = 1'b0;
        ar_stall_pct  = 0;
        r_stall_pct   = 0;
        slave_beat    = 0;
        cur_req       = -1;
        cycles        = 0;
        beats_seen    = 0;
        ar_errs       = 0;
        r_errs        = 0;
        ctl_errs      = 0;
        load_trace(ok);
        if (!ok) ctl_errs++;
        repeat (reset_cycles) @(posedge clock);
        rst_n <= 1'b1;
        if (ok) begin
            @(negedge clock);
            check_reset_state();                            // before any request.
            @(posedge clock);
            foreach (trace_req[i]) drive_request(i);        // back to back.
            long_arvalid <= 1'b0;
            while (exp_r.size() != 0 || exp_ar.size() != 0) @(posedge clock);
            repeat (4) @(posedge clock);                    // catch extra beats.
            check_piece_counts();
        end
        close_run();
    end

endmodule

//--- testbench/axi_rd_split_trace.txt
# one long read request per line, fields in this order:
# id(hex) addr(hex) len(hex, beats-1) pieces(dec) ar_stall_pct(dec) r_stall_pct(dec)
# stall percentages apply from the cycle the request is driven.
1 00001000 00 1 0 0
1 00002000 0f 1 0 0
2 00003000 10 2 0 0
3 00004000 ff 16 0 0
4 00010000 1f 2 20 20
5 00011000 00 1 30 30
6 00012000 7f 8 25 10
7 00013000 ff 16 50 50
8 00014000 03 1 10 40
9 00015000 2e 3 40 10
a 00016000 0e 1 0 60
b 00017000 10 2 60 0
c 00018000 ff 16 30 30
d 00019000 00 1 50 50
e 0001a000 00 1 50 50
f 0001b000 40 5 20 20
0 0001c000 8f 9 10 30
1 0001d000 fe 16 35 35
2 0001e000 01 1 0 0
3 0001f000 11 2 15 45
4 00020000 ff 16 0 70
5 00021000 5a 6 45 5
6 00022000 00 1 70 70
7 00023000 30 4 25 25
8 00024000 ff 16 20 20

//--- list.f
hdl/axi_rd_split_pkg.sv
hdl/burst_partitioner.sv
hdl/piece_flag_fifo.sv
hdl/read_return_merger.sv
hdl/axi_rd_split.sv
testbench/tb_axi_rd_split.sv

//--- Makefile
TOP = tb_axi_rd_split
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

obj_dir/V$(TOP): list.f hdl/*.sv testbench/*.sv
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		-Mdir obj_dir -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
